// ==== all.f ====
hw/rvPkg.sv
hw/memBus.sv
hw/controlUnit.sv
hw/immGen.sv
hw/alu.sv
hw/regFile.sv
hw/coreSeq.sv
hw/sharedMem.sv
hw/rvTop.sv
tb/tbRvTop.sv

// ==== tb/tbRvTop.sv ====
`timescale 1ns/1ps

module tbRvTop;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	// Each test stays below about 1500 cycles of load, run and readback
	localparam int CYCLE_LIMIT = 20000;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [31:0] ECALL = 32'h0000_0073;
	localparam logic [31:0] ALU_A = 32'hFFFF_FFEC; // -20
	localparam logic [31:0] ALU_B = 32'h0000_0F03; // Shift amount 3

	logic clk;
	logic rstN;
	logic run;
	logic hostReq;
	logic hostWe;
	logic [31:0] hostAddr;
	logic [31:0] hostWdata;
	logic hostGnt;
	logic [31:0] hostRdata;
	logic hostValid;
	logic halted;

	logic [31:0] prog [$]; // Assembled program, word 0 at address 0
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] resBase; // Result area, held in x10
	int resSlot;
	int errors;
	int checks;
	int testsRun;
	int unsigned cycles;

	rvTop i_rvTop (
		.clk, .rstN, .run, .hostReq, .hostWe, .hostAddr, .hostWdata,
		.hostGnt, .hostRdata, .hostValid, .halted
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(input logic [31:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(input logic [31:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] uType(input logic [31:0] upper, input logic [4:0] rd,
			input logic [6:0] op);
		return {upper[19:0], rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] fillValue(input logic [31:0] addr);
		return (addr * 32'h9E37_79B9) ^ 32'hC3A5_5A3C; // Every address bit matters
	endfunction

	function automatic logic [31:0] pcNow();
		return 32'(prog.size() * 4); // Address of the next instruction
	endfunction

	////////////////////////////////////////
	// Program building
	////////////////////////////////////////
	task automatic addInstr(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic addLoadImm(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12; // Round for the signed ADDI
		addInstr(uType(upper, rd, OP_LUI));
		addInstr(iType(value, rd, 3'b000, rd, OP_IMM));
	endtask

	task automatic expectWord(input logic [31:0] addr, input logic [31:0] value);
		expAddr.push_back(addr);
		expData.push_back(value);
	endtask

	task automatic storeResult(input logic [4:0] rs, input logic [31:0] expValue);
		addInstr(sType(resSlot * 4, rs, 5'd10, 3'b010)); // SW rs, slot(x10)
		expectWord(resBase + resSlot * 4, expValue);
		resSlot++;
	endtask

	task automatic beginProgram(input logic [31:0] base);
		prog.delete();
		expAddr.delete();
		expData.delete();
		resBase = base;
		resSlot = 0;
		addLoadImm(5'd10, base);
	endtask

	////////////////////////////////////////
	// Host port and core control
	////////////////////////////////////////
	task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		hostReq = 1'b1;
		hostWe = 1'b1;
		hostAddr = addr;
		hostWdata = data;
		@(negedge clk);
		while (!hostGnt) @(negedge clk);
		@(posedge clk); // Write lands here
		#1;
		hostReq = 1'b0;
		hostWe = 1'b0;
	endtask

	task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		hostReq = 1'b1;
		hostWe = 1'b0;
		hostAddr = addr;
		@(negedge clk);
		while (!hostGnt) @(negedge clk);
		@(posedge clk);
		#1;
		hostReq = 1'b0;
		@(negedge clk); // Data one cycle after grant
		if (!hostValid) begin
			errors++;
			$display("Host read of 0x%08h got no valid data after its grant", addr);
		end
		data = hostRdata;
	endtask

	task automatic fillRegion(input logic [31:0] base, input int words);
		for (int i = 0; i < words; i++) begin
			writeWord(base + i * 4, fillValue(base + i * 4));
		end
	endtask

	task automatic startCore();
		@(posedge clk);
		#1;
		run = 1'b0;
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(posedge clk);
		#1;
		run = 1'b1; // Rising edge starts the fetch
	endtask

	task automatic runProgram();
		addInstr(ECALL);
		for (int i = 0; i < prog.size(); i++) begin
			writeWord(i * 4, prog[i]);
		end
		startCore();
		@(negedge clk);
		while (!halted) @(negedge clk);
	endtask

	task automatic checkResults();
		logic [31:0] got;
		for (int i = 0; i < expAddr.size(); i++) begin
			readWord(expAddr[i], got);
			checks++;
			if (got !== expData[i]) begin
				errors++;
				$display("CHECK FAILED time %0t: word 0x%08h read 0x%08h, expected 0x%08h",
					$time, expAddr[i], got, expData[i]);
			end
		end
	endtask

	task automatic reportTest(input string name, input int errBefore, input int chkBefore);
		testsRun++;
		$display("%s: %0d checks, %0d errors", name, checks - chkBefore, errors - errBefore);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic testAlu();
		int errBefore;
		int chkBefore;
		errBefore = errors;
		chkBefore = checks;
		beginProgram(32'h800);
		addLoadImm(5'd1, ALU_A);
		addLoadImm(5'd2, ALU_B);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd4)); // ADD
		storeResult(5'd4, ALU_A + ALU_B);
		addInstr(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4)); // SUB
		storeResult(5'd4, ALU_A - ALU_B);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b001, 5'd4));
		storeResult(5'd4, ALU_A << 3);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd4)); // SLT, -20 < 3843
		storeResult(5'd4, 32'd1);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b011, 5'd4)); // SLTU sees a huge A
		storeResult(5'd4, 32'd0);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd4));
		storeResult(5'd4, ALU_A ^ ALU_B);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b101, 5'd4)); // SRL
		storeResult(5'd4, ALU_A >> 3);
		addInstr(rType(7'h20, 5'd2, 5'd1, 3'b101, 5'd4)); // SRA
		storeResult(5'd4, 32'hFFFF_FFFD);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
		storeResult(5'd4, ALU_A | ALU_B);
		addInstr(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd4));
		storeResult(5'd4, ALU_A & ALU_B);
		addInstr(iType(-5, 5'd1, 3'b000, 5'd4, OP_IMM)); // ADDI
		storeResult(5'd4, ALU_A - 32'd5);
		addInstr(iType(5, 5'd1, 3'b010, 5'd4, OP_IMM)); // SLTI
		storeResult(5'd4, 32'd1);
		addInstr(iType(5, 5'd1, 3'b011, 5'd4, OP_IMM)); // SLTIU
		storeResult(5'd4, 32'd0);
		addInstr(iType(-1, 5'd1, 3'b011, 5'd4, OP_IMM)); // Compares with all ones
		storeResult(5'd4, 32'd1);
		addInstr(iType(32'h0F0, 5'd1, 3'b100, 5'd4, OP_IMM));
		storeResult(5'd4, ALU_A ^ 32'h0F0);
		addInstr(iType(32'h700, 5'd1, 3'b110, 5'd4, OP_IMM));
		storeResult(5'd4, ALU_A | 32'h700);
		addInstr(iType(32'h7F0, 5'd1, 3'b111, 5'd4, OP_IMM));
		storeResult(5'd4, ALU_A & 32'h7F0);
		addInstr(iType(32'h004, 5'd1, 3'b001, 5'd4, OP_IMM)); // SLLI 4
		storeResult(5'd4, ALU_A << 4);
		addInstr(iType(32'h004, 5'd1, 3'b101, 5'd4, OP_IMM)); // SRLI 4
		storeResult(5'd4, ALU_A >> 4);
		addInstr(iType(32'h404, 5'd1, 3'b101, 5'd4, OP_IMM)); // SRAI 4
		storeResult(5'd4, 32'hFFFF_FFFE);
		fillRegion(32'h800, 24);
		runProgram();
		checkResults();
		reportTest("alu", errBefore, chkBefore);
	endtask

	task automatic testLoadStore();
		int errBefore;
		int chkBefore;
		logic [7:0] bval [4];
		logic [31:0] word;
		errBefore = errors;
		chkBefore = checks;
		bval[0] = 8'h81;
		bval[1] = 8'h7E;
		bval[2] = 8'hC3;
		bval[3] = 8'h3C;
		beginProgram(32'hA00);
		addLoadImm(5'd12, 32'h900); // Data area
		for (int k = 0; k < 4; k++) begin // Byte k of word k
			addLoadImm(5'd1, {24'h123456, bval[k]});
			addInstr(sType(5 * k, 5'd1, 5'd12, 3'b000));
			word = fillValue(32'h900 + 4 * k);
			word[8 * k +: 8] = bval[k];
			expectWord(32'h900 + 4 * k, word);
		end
		addLoadImm(5'd1, 32'hFFFF_8ABC);
		addInstr(sType(16, 5'd1, 5'd12, 3'b001)); // Low half of word 4
		addLoadImm(5'd1, 32'h0000_4DEF);
		addInstr(sType(22, 5'd1, 5'd12, 3'b001)); // High half of word 5
		addLoadImm(5'd1, 32'hCAFE_F00D);
		addInstr(sType(24, 5'd1, 5'd12, 3'b010));
		word = fillValue(32'h910);
		word[15:0] = 16'h8ABC;
		expectWord(32'h910, word);
		word = fillValue(32'h914);
		word[31:16] = 16'h4DEF;
		expectWord(32'h914, word);
		expectWord(32'h918, 32'hCAFE_F00D);
		expectWord(32'h91C, fillValue(32'h91C)); // Untouched neighbor
		for (int k = 0; k < 4; k++) begin
			addInstr(iType(5 * k, 5'd12, 3'b000, 5'd5, OP_LOAD)); // LB
			storeResult(5'd5, {{24{bval[k][7]}}, bval[k]});
			addInstr(iType(5 * k, 5'd12, 3'b100, 5'd5, OP_LOAD)); // LBU
			storeResult(5'd5, {24'h0, bval[k]});
		end
		addInstr(iType(16, 5'd12, 3'b001, 5'd5, OP_LOAD)); // LH
		storeResult(5'd5, 32'hFFFF_8ABC);
		addInstr(iType(16, 5'd12, 3'b101, 5'd5, OP_LOAD)); // LHU
		storeResult(5'd5, 32'h0000_8ABC);
		addInstr(iType(22, 5'd12, 3'b001, 5'd5, OP_LOAD));
		storeResult(5'd5, 32'h0000_4DEF);
		addInstr(iType(22, 5'd12, 3'b101, 5'd5, OP_LOAD));
		storeResult(5'd5, 32'h0000_4DEF);
		addInstr(iType(24, 5'd12, 3'b010, 5'd5, OP_LOAD)); // LW
		storeResult(5'd5, 32'hCAFE_F00D);
		fillRegion(32'h900, 8);
		fillRegion(32'hA00, 16);
		runProgram();
		checkResults();
		reportTest("loadstore", errBefore, chkBefore);
	endtask

	// Taken skips the ADDI of 2, so the slot holds 1
	task automatic addBranch(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input bit taken);
		addInstr(iType(1, 5'd0, 3'b000, 5'd5, OP_IMM));
		addInstr(bType(8, rs2, rs1, f3));
		addInstr(iType(2, 5'd0, 3'b000, 5'd5, OP_IMM));
		storeResult(5'd5, taken ? 32'd1 : 32'd2);
	endtask

	task automatic testBranch();
		int errBefore;
		int chkBefore;
		logic [31:0] sum;
		errBefore = errors;
		chkBefore = checks;
		beginProgram(32'hB00);
		addLoadImm(5'd1, 32'hFFFF_FFFF); // -1, or the largest unsigned
		addLoadImm(5'd2, 32'd1);
		addLoadImm(5'd3, 32'd1);
		addBranch(3'b000, 5'd2, 5'd3, 1'b1); // BEQ
		addBranch(3'b000, 5'd1, 5'd2, 1'b0);
		addBranch(3'b001, 5'd1, 5'd2, 1'b1); // BNE
		addBranch(3'b001, 5'd2, 5'd3, 1'b0);
		addBranch(3'b100, 5'd1, 5'd2, 1'b1); // BLT
		addBranch(3'b100, 5'd2, 5'd1, 1'b0);
		addBranch(3'b101, 5'd2, 5'd1, 1'b1); // BGE
		addBranch(3'b101, 5'd1, 5'd2, 1'b0);
		addBranch(3'b101, 5'd2, 5'd3, 1'b1); // Equal counts as greater or equal
		addBranch(3'b110, 5'd2, 5'd1, 1'b1); // BLTU
		addBranch(3'b110, 5'd1, 5'd2, 1'b0);
		addBranch(3'b111, 5'd1, 5'd2, 1'b1); // BGEU
		addBranch(3'b111, 5'd2, 5'd1, 1'b0);
		addInstr(iType(0, 5'd0, 3'b000, 5'd6, OP_IMM)); // Sum
		addInstr(iType(1, 5'd0, 3'b000, 5'd7, OP_IMM)); // Counter
		addInstr(iType(11, 5'd0, 3'b000, 5'd8, OP_IMM)); // Bound
		addInstr(rType(7'h00, 5'd7, 5'd6, 3'b000, 5'd6)); // Loop body
		addInstr(iType(1, 5'd7, 3'b000, 5'd7, OP_IMM));
		addInstr(bType(-8, 5'd8, 5'd7, 3'b100)); // Back to the ADD
		sum = 0;
		for (int i = 1; i <= 10; i++) sum += i;
		storeResult(5'd6, sum);
		fillRegion(32'hB00, 16);
		runProgram();
		checkResults();
		reportTest("branch", errBefore, chkBefore);
	endtask

	task automatic testJump();
		int errBefore;
		int chkBefore;
		logic [31:0] pc;
		errBefore = errors;
		chkBefore = checks;
		beginProgram(32'hC00);
		addLoadImm(5'd15, 32'h0000_0BAD); // Marker value
		addInstr(uType(32'h12345, 5'd12, OP_LUI));
		storeResult(5'd12, 32'h1234_5000);
		pc = pcNow();
		addInstr(uType(32'h00001, 5'd13, OP_AUIPC));
		storeResult(5'd13, pc + 32'h1000);
		pc = pcNow();
		addInstr(jType(12, 5'd14)); // Over two marker stores
		addInstr(sType(32'h40, 5'd15, 5'd10, 3'b010));
		addInstr(sType(32'h44, 5'd15, 5'd10, 3'b010));
		storeResult(5'd14, pc + 4);
		pc = pcNow();
		addInstr(uType(32'h0, 5'd16, OP_AUIPC));
		addInstr(iType(13, 5'd16, 3'b000, 5'd17, OP_JALR)); // Odd target, bit 0 dropped
		addInstr(sType(32'h48, 5'd15, 5'd10, 3'b010));
		storeResult(5'd17, pc + 8);
		addInstr(uType(32'h0, 5'd18, OP_AUIPC)); // Odd PC would show up here
		storeResult(5'd18, pc + 16);
		expectWord(32'hC40, fillValue(32'hC40));
		expectWord(32'hC44, fillValue(32'hC44));
		expectWord(32'hC48, fillValue(32'hC48));
		fillRegion(32'hC00, 32);
		runProgram();
		checkResults();
		reportTest("jump", errBefore, chkBefore);
	endtask

	task automatic testZeroReg();
		int errBefore;
		int chkBefore;
		logic [31:0] got;
		errBefore = errors;
		chkBefore = checks;
		beginProgram(32'hD00);
		addLoadImm(5'd1, 32'h1357_9BDF);
		addInstr(iType(77, 5'd0, 3'b000, 5'd0, OP_IMM));
		storeResult(5'd0, 32'd0);
		addInstr(rType(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
		storeResult(5'd0, 32'd0);
		addInstr(uType(32'hFFFFF, 5'd0, OP_LUI));
		storeResult(5'd0, 32'd0);
		addInstr(iType(32'h20, 5'd10, 3'b010, 5'd0, OP_LOAD)); // Load of a filled word
		storeResult(5'd0, 32'd0);
		storeResult(5'd1, 32'h1357_9BDF);
		fillRegion(32'hD00, 16);
		runProgram();
		repeat (20) @(negedge clk);
		checks++;
		if (!halted) begin
			errors++;
			$display("CHECK FAILED time %0t: halted dropped while run stayed high", $time);
		end
		checkResults();
		readWord(32'h0, got); // Program word after halt
		checks++;
		if (got !== prog[0]) begin
			errors++;
			$display("CHECK FAILED time %0t: word 0x00000000 read 0x%08h, expected 0x%08h",
				$time, got, prog[0]);
		end
		checks++;
		if (!halted) begin
			errors++;
			$display("CHECK FAILED time %0t: halted dropped during host reads", $time);
		end
		@(negedge clk); // Host port idle again
		checks++;
		if (hostGnt || hostValid) begin
			errors++;
			$display("CHECK FAILED time %0t: hostGnt %0b hostValid %0b with no request",
				$time, hostGnt, hostValid);
		end
		reportTest("zeroreg", errBefore, chkBefore);
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWdata = '0;
		errors = 0;
		checks = 0;
		testsRun = 0;
		cycles = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rstN = 1'b1;
		testAlu();
		testLoadStore();
		testBranch();
		testJump();
		testZeroReg();
		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

// ==== hw/rvTop.sv ====
`timescale 1ns/1ps

module rvTop import rvPkg::*; (
	input logic clk,
	input logic rstN,
	input logic run, // Start on rising edge
	input logic hostReq,
	input logic hostWe,
	input logic [ADDR_W-1:0] hostAddr,
	input logic [31:0] hostWdata,
	output logic hostGnt,
	output logic [31:0] hostRdata,
	output logic hostValid,
	output logic halted
);
	memBus hostBus ();
	memBus dataBus ();
	memBus fetchBus ();

	// Host side, full words only
	assign hostBus.req = hostReq;
	assign hostBus.we = hostWe;
	assign hostBus.addr = hostAddr;
	assign hostBus.wdata = hostWdata;
	assign hostBus.be = 4'hF;
	assign hostGnt = hostBus.gnt;
	assign hostRdata = hostBus.rdata;
	assign hostValid = hostBus.rvalid;

	coreSeq i_coreSeq (
		.clk, .rstN, .run, .halted,
		.fetchBus(fetchBus.requester),
		.dataBus(dataBus.requester)
	);

	sharedMem i_sharedMem (
		.clk, .rstN,
		.hostBus(hostBus.memory),
		.dataBus(dataBus.memory),
		.fetchBus(fetchBus.memory)
	);
endmodule

// ==== hw/sharedMem.sv ====
`timescale 1ns/1ps

module sharedMem import rvPkg::*; (
	input logic clk,
	input logic rstN,
	memBus.memory hostBus,
	memBus.memory dataBus,
	memBus.memory fetchBus
);
	logic [31:0] mem [MEM_WORDS]; // Code and data
	logic [2:0] grant; // One-hot {fetch, data, host}
	logic [2:0] readQ; // Per-bus rvalid
	logic [31:0] rdataQ;
	logic weSel;
	logic [ADDR_W-1:0] addrSel;
	logic [31:0] wdataSel;
	logic [3:0] beSel;
	logic [MEM_AW-1:0] wordIdx;

	////////////////////////////////////////
	// Fixed priority host > data > fetch
	////////////////////////////////////////
	assign grant[0] = hostBus.req;
	assign grant[1] = dataBus.req && !hostBus.req;
	assign grant[2] = fetchBus.req && !hostBus.req && !dataBus.req;

	always_comb begin
		case (grant)
			3'b001: {weSel, addrSel, wdataSel, beSel} =
				{hostBus.we, hostBus.addr, hostBus.wdata, hostBus.be};
			3'b010: {weSel, addrSel, wdataSel, beSel} =
				{dataBus.we, dataBus.addr, dataBus.wdata, dataBus.be};
			default: {weSel, addrSel, wdataSel, beSel} =
				{fetchBus.we, fetchBus.addr, fetchBus.wdata, fetchBus.be}; // Idle too
		endcase
	end

	assign wordIdx = addrSel[MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (|grant) begin
			if (weSel) begin
				for (int i = 0; i < 4; i++) begin
					if (beSel[i])
						mem[wordIdx][8*i +: 8] <= wdataSel[8*i +: 8]; // Enabled lanes only
				end
			end else begin
				rdataQ <= mem[wordIdx];
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			readQ <= '0;
		else
			readQ <= grant & {3{!weSel}}; // Reads only
	end

	assign hostBus.gnt = grant[0];
	assign dataBus.gnt = grant[1];
	assign fetchBus.gnt = grant[2];
	assign hostBus.rvalid = readQ[0];
	assign dataBus.rvalid = readQ[1];
	assign fetchBus.rvalid = readQ[2];
	assign hostBus.rdata = rdataQ; // Shared read register
	assign dataBus.rdata = rdataQ;
	assign fetchBus.rdata = rdataQ;
endmodule

// ==== hw/coreSeq.sv ====
`timescale 1ns/1ps

module coreSeq import rvPkg::*; (
	input logic clk,
	input logic rstN,
	input logic run,
	output logic halted,
	memBus.requester fetchBus,
	memBus.requester dataBus
);
	coreStateE state, nextState;
	logic [ADDR_W-1:0] pc;
	logic [31:0] ir; // Instruction register
	logic [31:0] loadData; // Aligned and extended load result
	logic runQ;
	opcodeE opcode;
	aluOpE aluOp;
	immTypeE immType;
	logic immSel, setDataZero, regWriteEnable, memRead, memWrite;
	logic branch, pcOperand, jump, jumpAl, addConstant4, halt;
	logic [2:0] memType;
	logic [31:0] imm, rd1, rd2, opA, opB, aluResult, wbData, loadShift, storeData;
	logic [ADDR_W-1:0] pcPlus4, nextPc, memMask;
	logic branchTaken, isMem;
	logic [1:0] byteOff;
	logic [3:0] storeBe;

	controlUnit i_controlUnit (
		.instr(ir), .aluOp, .immType, .immSel, .setDataZero, .regWriteEnable, .memRead,
		.memWrite, .branch, .pcOperand, .jump, .jumpAl, .addConstant4, .memType, .halt
	);
	immGen i_immGen (.instr(ir), .immType, .imm);
	alu i_alu (.aluOp, .a(opA), .b(opB), .funct3(ir[14:12]), .result(aluResult), .branchTaken);
	regFile i_regFile (
		.clk, .rstN, .rs1(ir[19:15]), .rs2(ir[24:20]), .rd(ir[11:7]),
		.wrEn(state == stWb && regWriteEnable), .wrData(wbData), .rd1, .rd2
	);

	assign opcode = opcodeE'(ir[6:0]);
	assign isMem = (opcode == opLoad) || (opcode == opStore); // Needs data phase
	assign opA = pcOperand ? pc : (setDataZero ? '0 : rd1);
	assign opB = immSel ? imm : rd2;
	assign pcPlus4 = pc + 32'd4;
	assign wbData = addConstant4 ? pcPlus4 : (memRead ? loadData : aluResult);
	assign memMask = ADDR_W'((MEM_WORDS << 2) - 4); // Word aligned, inside the array
	assign byteOff = aluResult[1:0];
	assign halted = (state == stHalt);

	always_comb begin
		if (jump)
			nextPc = jumpAl ? aluResult : {aluResult[31:1], 1'b0}; // JALR clears bit 0
		else if (branch && branchTaken)
			nextPc = pc + imm;
		else
			nextPc = pcPlus4;
	end

	////////////////////////////////////////
	// Bus requests
	////////////////////////////////////////
	assign fetchBus.req = (state == stFetch);
	assign fetchBus.we = 1'b0;
	assign fetchBus.addr = pc & memMask;
	assign fetchBus.wdata = '0;
	assign fetchBus.be = 4'hF;
	assign dataBus.req = (state == stMem);
	assign dataBus.we = memWrite;
	assign dataBus.addr = aluResult & memMask;
	assign dataBus.wdata = storeData;
	assign dataBus.be = storeBe;

	always_comb begin
		case (memType[1:0])
			2'b00: begin // SB, replicate to every lane
				storeBe = 4'b0001 << byteOff;
				storeData = {4{rd2[7:0]}};
			end
			2'b01: begin // SH
				storeBe = 4'b0011 << {byteOff[1], 1'b0};
				storeData = {2{rd2[15:0]}};
			end
			default: begin
				storeBe = 4'hF;
				storeData = rd2;
			end
		endcase
	end

	assign loadShift = dataBus.rdata >> {byteOff, 3'b000}; // Addressed byte to lane 0

	always_ff @(posedge clk) begin
		if (dataBus.rvalid) begin
			case (memType)
				3'b000: loadData <= {{24{loadShift[7]}}, loadShift[7:0]}; // LB
				3'b001: loadData <= {{16{loadShift[15]}}, loadShift[15:0]}; // LH
				3'b100: loadData <= {24'b0, loadShift[7:0]}; // LBU
				3'b101: loadData <= {16'b0, loadShift[15:0]}; // LHU
				default: loadData <= loadShift;
			endcase
		end
	end

	////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////
	always_comb begin
		nextState = state;
		case (state)
			stIdle: if (run && !runQ) nextState = stFetch; // Rising edge of run
			stFetch: if (fetchBus.gnt) nextState = stFetchWait; // Stretched by contention
			stFetchWait: if (fetchBus.rvalid) nextState = stExec;
			stExec: begin
				if (halt)
					nextState = stHalt;
				else if (isMem)
					nextState = stMem;
				else
					nextState = stWb;
			end
			stMem: if (dataBus.gnt) nextState = stMemWait;
			stMemWait: if (dataBus.rvalid || memWrite) nextState = stWb; // Stores get no rvalid
			stWb: nextState = stFetch;
			default: nextState = stHalt; // Held until reset
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
			pc <= RESET_PC;
			ir <= '0;
			runQ <= 1'b0;
		end else begin
			state <= nextState;
			runQ <= run;
			if (state == stIdle && run && !runQ)
				pc <= RESET_PC; // Restart point
			else if (state == stWb)
				pc <= nextPc;
			if (fetchBus.rvalid)
				ir <= fetchBus.rdata;
		end
	end
endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic wrEn,
	input logic [31:0] wrData,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);
	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= wrData;
		end
	end

	assign rd1 = regs[rs1]; // Async read
	assign rd2 = regs[rs2];
endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import rvPkg::*; (
	input aluOpE aluOp,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [2:0] funct3, // Branch condition select
	output logic [31:0] result,
	output logic branchTaken
);
	logic [4:0] shamt;

	assign shamt = b[4:0]; // Only low five bits shift

	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluSll: result = a << shamt;
			aluSlt: result = {31'b0, $signed(a) < $signed(b)};
			aluSltu: result = {31'b0, a < b};
			aluXor: result = a ^ b;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt; // Keeps the sign
			aluOr: result = a | b;
			aluAnd: result = a & b;
			default: result = '0;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000: branchTaken = (a == b); // BEQ
			3'b001: branchTaken = (a != b); // BNE
			3'b100: branchTaken = ($signed(a) < $signed(b)); // BLT
			3'b101: branchTaken = ($signed(a) >= $signed(b)); // BGE
			3'b110: branchTaken = (a < b); // BLTU
			3'b111: branchTaken = (a >= b); // BGEU
			default: branchTaken = 1'b0;
		endcase
	end
endmodule

// ==== hw/immGen.sv ====
`timescale 1ns/1ps

module immGen import rvPkg::*; (
	input logic [31:0] instr,
	input immTypeE immType,
	output logic [31:0] imm
);
	logic sign; // Bit 31 is the sign for every format

	assign sign = instr[31];

	always_comb begin
		case (immType)
			immI: imm = {{20{sign}}, instr[31:20]};
			immIz: imm = {20'b0, instr[31:20]};
			immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
			immB: begin // Halfword offset
				imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			immU: imm = {instr[31:12], 12'b0};
			immJ: begin // Halfword offset, 21 bits
				imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: imm = '0;
		endcase
	end
endmodule

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
	input logic [31:0] instr,
	output aluOpE aluOp,
	output immTypeE immType,
	output logic immSel, // ALU source b is the immediate
	output logic setDataZero, // ALU source a forced to zero
	output logic regWriteEnable,
	output logic memRead,
	output logic memWrite,
	output logic branch,
	output logic pcOperand, // ALU source a is the PC
	output logic jump,
	output logic jumpAl, // JAL, target used as is
	output logic addConstant4, // Link value PC+4
	output logic [2:0] memType, // funct3 of load/store
	output logic halt
);
	opcodeE opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	aluOpE arithOp; // ALU op from funct3/funct7

	assign opcode = opcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	////////////////////////////////////////
	// ALU op for OP and OP-IMM
	////////////////////////////////////////
	always_comb begin
		case (funct3)
			3'b000: arithOp = (funct7 == 7'b0100000 && opcode == opOp) ? aluSub : aluAdd;
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = (funct7 == 7'b0100000) ? aluSra : aluSrl; // SRAI/SRA on funct7
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	end

	////////////////////////////////////////
	// Per-opcode controls
	////////////////////////////////////////
	always_comb begin
		aluOp = aluAdd; // Inactive defaults
		immType = immI;
		immSel = 1'b0;
		setDataZero = 1'b0;
		regWriteEnable = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		pcOperand = 1'b0;
		jump = 1'b0;
		jumpAl = 1'b0;
		addConstant4 = 1'b0;
		memType = 3'b000;
		halt = 1'b0;
		case (opcode)
			opLui: begin // 0 + imm
				setDataZero = 1'b1;
				immSel = 1'b1;
				immType = immU;
				regWriteEnable = 1'b1;
			end
			opAuipc: begin // PC + imm
				immSel = 1'b1;
				immType = immU;
				pcOperand = 1'b1;
				regWriteEnable = 1'b1;
			end
			opJal: begin // Target PC + imm, link PC+4
				immSel = 1'b1;
				immType = immJ;
				pcOperand = 1'b1;
				regWriteEnable = 1'b1;
				jump = 1'b1;
				jumpAl = 1'b1;
				addConstant4 = 1'b1;
			end
			opJalr: begin
				// Target is rs1 + imm, so the PC is not an operand here
				immSel = 1'b1;
				immType = immI;
				regWriteEnable = 1'b1;
				jump = 1'b1;
				addConstant4 = 1'b1;
			end
			opBranch: begin // ALU compares rs1/rs2, imm only for target
				branch = 1'b1;
				immType = immB;
			end
			opLoad: begin
				immSel = 1'b1;
				immType = immI;
				regWriteEnable = 1'b1;
				memRead = 1'b1;
				memType = funct3;
			end
			opStore: begin
				immSel = 1'b1;
				immType = immS;
				memWrite = 1'b1;
				memType = funct3;
			end
			opOpImm: begin
				immSel = 1'b1;
				immType = immI;
				regWriteEnable = 1'b1;
				aluOp = arithOp;
			end
			opOp: begin
				regWriteEnable = 1'b1;
				aluOp = arithOp;
			end
			opSystem: halt = 1'b1; // ECALL/EBREAK stop the core
			default: halt = 1'b0; // Unknown opcodes act as NOP
		endcase
	end
endmodule

// ==== hw/memBus.sv ====
`timescale 1ns/1ps

interface memBus import rvPkg::*; ();
	logic req; // Held until gnt
	logic we;
	logic [ADDR_W-1:0] addr; // Word aligned byte address
	logic [31:0] wdata;
	logic [3:0] be; // Byte lanes
	logic gnt; // Access happens this cycle
	logic [31:0] rdata;
	logic rvalid; // One cycle after gnt on reads

	modport requester (
		output req, we, addr, wdata, be,
		input gnt, rdata, rvalid
	);

	modport memory (
		input req, we, addr, wdata, be,
		output gnt, rdata, rvalid
	);
endinterface

// ==== hw/rvPkg.sv ====
package rvPkg;

	////////////////////////////////////////
	// Memory map
	////////////////////////////////////////
	localparam int MEM_WORDS = 1024; // Unified memory depth in words
	localparam int MEM_AW = $clog2(MEM_WORDS); // Word index width
	localparam int ADDR_W = 32; // Byte address width
	localparam logic [ADDR_W-1:0] RESET_PC = '0; // First fetch address

	////////////////////////////////////////
	// Decode encodings
	////////////////////////////////////////
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011 // ECALL/EBREAK, halt only
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOpE;

	typedef enum logic [2:0] {
		immI  = 3'd0, // Sign extended
		immIz = 3'd1, // Zero extended
		immS  = 3'd2,
		immB  = 3'd3,
		immU  = 3'd4,
		immJ  = 3'd5
	} immTypeE;

	typedef enum logic [2:0] {
		stIdle, stFetch, stFetchWait, stExec, stMem, stMemWait, stWb, stHalt
	} coreStateE;

endpackage
